// File: source/srt_div_pkg.sv
// srt divider package with widths, word types, the state enum and the stage records
`default_nettype none

package srt_div_pkg;

    localparam int WORD_W  = 32;
    localparam int SHIFT_W = 6;

    typedef logic [WORD_W-1:0]  word_t;
    // one sign bit above a word
    typedef logic [WORD_W:0]    ext_word_t;
    typedef logic [SHIFT_W-1:0] shift_t;

    typedef enum logic [1:0] {
        IDLE,
        NORMALIZE,
        ITERATE,
        FINISH
    } div_state_e;

    typedef struct packed {
        word_t  dividend_mag;
        word_t  divisor_mag;
        shift_t dividend_lz;
        shift_t divisor_lz;
        logic   quot_neg;
        logic   rem_neg;
        logic   divisor_zero;
    } operand_t;

    typedef struct packed {
        ext_word_t part_rem;
        word_t     pos_digits;
        word_t     neg_digits;
        shift_t    restore_shift;
    } iter_result_t;

endpackage

`default_nettype wire

// File: source/leading_zero_counter.sv
// leading zero counter, binary search over halving groups, full width for a zero word
`timescale 1ns/100ps
`default_nettype none

module leading_zero_counter
    import srt_div_pkg::*;
(
    input  word_t  data,
    output shift_t zero_count
);

    always_comb begin : search
        word_t  v;
        shift_t n;
        v = data;
        n = '0;
        // each step drops the upper half when it is empty
        if (v[WORD_W-1 -: 16] == '0) begin
            n[4] = 1'b1;
            v = v << 16;
        end
        if (v[WORD_W-1 -: 8] == '0) begin
            n[3] = 1'b1;
            v = v << 8;
        end
        if (v[WORD_W-1 -: 4] == '0) begin
            n[2] = 1'b1;
            v = v << 4;
        end
        if (v[WORD_W-1 -: 2] == '0) begin
            n[1] = 1'b1;
            v = v << 2;
        end
        if (!v[WORD_W-1]) begin
            n[0] = 1'b1;
            v = v << 1;
        end
        // still zero at the top means the whole word was zero
        zero_count = n + shift_t'(!v[WORD_W-1]);
    end

endmodule

`default_nettype wire

// File: source/operand_prep.sv
// operand capture, takes magnitudes and signs and counts leading zeros of both
`timescale 1ns/100ps
`default_nettype none

module operand_prep
    import srt_div_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  logic     div_signed,
    input  word_t    x,
    input  word_t    y,
    output operand_t operands
);

    logic   x_neg;
    logic   y_neg;
    word_t  x_mag;
    word_t  y_mag;
    shift_t x_lz;
    shift_t y_lz;

    // sign bits only count in signed mode
    assign x_neg = div_signed & x[WORD_W-1];
    assign y_neg = div_signed & y[WORD_W-1];

    // -2^31 keeps its pattern and reads as 2^31 unsigned
    assign x_mag = x_neg ? -x : x;
    assign y_mag = y_neg ? -y : y;

    leading_zero_counter dividend_lzc (
        .data       (x_mag),
        .zero_count (x_lz)
    );

    leading_zero_counter divisor_lzc (
        .data       (y_mag),
        .zero_count (y_lz)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            operands <= '0;
        end else if (load) begin
            operands.dividend_mag <= x_mag;
            operands.divisor_mag  <= y_mag;
            operands.dividend_lz  <= x_lz;
            operands.divisor_lz   <= y_lz;
            operands.quot_neg     <= x_neg ^ y_neg;
            operands.rem_neg      <= x_neg;
            operands.divisor_zero <= (y_lz == SHIFT_W'(WORD_W));
        end
    end

endmodule

`default_nettype wire

// File: source/srt_iteration.sv
// srt iteration control, normalizes the operands and runs the radix-2 recurrence
`timescale 1ns/100ps
`default_nettype none

module srt_iteration
    import srt_div_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         div,
    input  operand_t     operands,
    output logic         load,
    output logic         finish,
    output logic         div_zero,
    output iter_result_t result
);

    div_state_e   state;
    shift_t       rounds_left;
    word_t        divisor_norm;
    iter_result_t acc;

    ext_word_t    div_ext;
    ext_word_t    step_rem;
    logic         take_pos;
    logic         take_neg;
    logic         short_path;
    logic         last_round;

    // dividend shorter than divisor, quotient is zero
    assign short_path = operands.dividend_lz > operands.divisor_lz;
    assign last_round = (rounds_left == '0);
    assign div_ext    = {1'b0, divisor_norm};

    assign load     = (state == IDLE) && div;
    assign finish   = (state == FINISH) && div && !operands.divisor_zero;
    assign div_zero = (state == FINISH) && div && operands.divisor_zero;
    assign result   = acc;

    // digit selection on the top two bits of the partial remainder
    always_comb begin
        step_rem = acc.part_rem;
        take_pos = 1'b0;
        take_neg = 1'b0;
        case (acc.part_rem[WORD_W -: 2])
            2'b01: begin
                step_rem = acc.part_rem - div_ext;
                take_pos = 1'b1;
            end
            2'b10: begin
                step_rem = acc.part_rem + div_ext;
                take_neg = 1'b1;
            end
            default: begin
                step_rem = acc.part_rem;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            rounds_left <= '0;
        end else if (!div) begin
            // dropped request abandons the division
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    state <= NORMALIZE;
                end
                NORMALIZE: begin
                    rounds_left <= operands.divisor_lz - operands.dividend_lz;
                    if (operands.divisor_zero || short_path) begin
                        state <= FINISH;
                    end else begin
                        state <= ITERATE;
                    end
                end
                ITERATE: begin
                    if (last_round) begin
                        state <= FINISH;
                    end else begin
                        rounds_left <= rounds_left - 1'b1;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            NORMALIZE: begin
                divisor_norm      <= operands.divisor_mag << operands.divisor_lz;
                acc.pos_digits    <= '0;
                acc.neg_digits    <= '0;
                acc.restore_shift <= operands.divisor_lz;
                if (short_path) begin
                    // aligned to the divisor so the restore shift gives it back
                    acc.part_rem <= {1'b0, operands.dividend_mag << operands.divisor_lz};
                end else begin
                    acc.part_rem <= {1'b0, operands.dividend_mag << operands.dividend_lz};
                end
            end
            ITERATE: begin
                acc.pos_digits <= {acc.pos_digits[WORD_W-2:0], take_pos};
                acc.neg_digits <= {acc.neg_digits[WORD_W-2:0], take_neg};
                // no shift after the last digit
                if (last_round) begin
                    acc.part_rem <= step_rem;
                end else begin
                    acc.part_rem <= step_rem << 1;
                end
            end
            default: begin
                acc <= acc;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/result_fixup.sv
// result fixup, turns the digit words into a quotient and restores and signs the remainder
`timescale 1ns/100ps
`default_nettype none

module result_fixup
    import srt_div_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         finish,
    input  logic         div_zero,
    input  operand_t     operands,
    input  iter_result_t result,
    output word_t        q,
    output word_t        rem,
    output logic         complete,
    output logic         div0_err
);

    word_t     quot_mag;
    word_t     rem_mag;
    ext_word_t rem_fix;
    ext_word_t rem_shifted;
    ext_word_t div_ext;

    // divisor at the scale of the final partial remainder
    assign div_ext = {1'b0, operands.divisor_mag << result.restore_shift};

    always_comb begin
        quot_mag = result.pos_digits - result.neg_digits;
        rem_fix  = result.part_rem;
        // negative remainder means the last digit overshot
        if (result.part_rem[WORD_W]) begin
            rem_fix  = result.part_rem + div_ext;
            quot_mag = quot_mag - 1'b1;
        end
        rem_shifted = rem_fix >> result.restore_shift;
        rem_mag     = rem_shifted[WORD_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q        <= '0;
            rem      <= '0;
            complete <= 1'b0;
            div0_err <= 1'b0;
        end else begin
            complete <= finish | div_zero;
            if (finish) begin
                q        <= operands.quot_neg ? -quot_mag : quot_mag;
                rem      <= operands.rem_neg ? -rem_mag : rem_mag;
                div0_err <= 1'b0;
            end else if (div_zero) begin
                // q and rem keep the last good result
                div0_err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/srt_divider.sv
// srt divider top, operand capture, iteration and result fixup in a chain
`timescale 1ns/100ps
`default_nettype none

module srt_divider
    import srt_div_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  div,
    input  logic  div_signed,
    input  word_t x,
    input  word_t y,
    output word_t q,
    output word_t rem,
    output logic  complete,
    output logic  div0_err
);

    operand_t     operands;
    iter_result_t iter_result;
    logic         load;
    logic         finish;
    logic         div_zero;

    operand_prep u_operand_prep (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .div_signed (div_signed),
        .x          (x),
        .y          (y),
        .operands   (operands)
    );

    srt_iteration u_srt_iteration (
        .clk      (clk),
        .reset    (reset),
        .div      (div),
        .operands (operands),
        .load     (load),
        .finish   (finish),
        .div_zero (div_zero),
        .result   (iter_result)
    );

    result_fixup u_result_fixup (
        .clk      (clk),
        .reset    (reset),
        .finish   (finish),
        .div_zero (div_zero),
        .operands (operands),
        .result   (iter_result),
        .q        (q),
        .rem      (rem),
        .complete (complete),
        .div0_err (div0_err)
    );

endmodule

`default_nettype wire

// File: verif/clock_gen.sv
// clock and reset source for the divider testbench, 40 ns period, reset for 8 cycles
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/result_checker.sv
// result checker, models truncating division and compares every completion with it
`timescale 1ns/100ps
`default_nettype none

module result_checker
    import srt_div_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  div,
    input  logic  div_signed,
    input  word_t x,
    input  word_t y,
    input  word_t q,
    input  word_t rem,
    input  logic  complete,
    input  logic  div0_err,
    output int    tests,
    output int    errors
);

    word_t x_cap;
    word_t y_cap;
    logic  signed_cap;
    // set while a division runs in the DUT
    logic  pending;
    logic  complete_prev;
    // last good result stays in place over a zero divisor
    word_t model_q;
    word_t model_rem;

    task automatic compare(input string name, input word_t exp, input word_t act,
                           inout bit ok);
        if (exp !== act) begin
            $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
            ok = 1'b0;
        end
    endtask

    initial begin
        tests         = 0;
        errors        = 0;
        pending       = 1'b0;
        complete_prev = 1'b0;
        model_q       = '0;
        model_rem     = '0;
    end

    // sampled on the falling edge
    always @(negedge clk) begin : watch
        longint num;
        longint den;
        longint quo;
        bit     ok;
        if (reset) begin
            pending       = 1'b0;
            complete_prev = 1'b0;
        end else begin
            if (complete) begin
                ok    = 1'b1;
                tests = tests + 1;
                if (complete_prev) begin
                    $display("complete still high one cycle later at %0d ns", $time);
                    ok = 1'b0;
                end
                if (!pending) begin
                    $display("complete at %0d ns without a division in progress", $time);
                    ok = 1'b0;
                end else if (y_cap == '0) begin
                    compare("div0_err", 1, word_t'(div0_err), ok);
                end else begin
                    num = signed_cap ? longint'($signed(x_cap)) : longint'(x_cap);
                    den = signed_cap ? longint'($signed(y_cap)) : longint'(y_cap);
                    quo = num / den;
                    // -2^31 / -1 wraps when cut back to a word
                    model_q   = word_t'(quo);
                    model_rem = word_t'(num - quo * den);
                    compare("div0_err", 0, word_t'(div0_err), ok);
                end
                compare("q", model_q, q, ok);
                compare("rem", model_rem, rem, ok);
                if (!ok) begin
                    errors = errors + 1;
                end
                $display("test %0d %s %0h / %0h: q %0h rem %0h div0_err %0b, %s", tests,
                         signed_cap ? "signed" : "unsigned", x_cap, y_cap, q, rem,
                         div0_err, ok ? "ok" : "error");
                pending = 1'b0;
            end
            complete_prev = complete;
            // div as the next rising edge sees it
            if (!div) begin
                // a dropped request abandons the division
                pending = 1'b0;
            end else if (!pending) begin
                // an idle unit starts on the next edge, also right after complete
                x_cap      = x;
                y_cap      = y;
                signed_cap = div_signed;
                pending    = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_srt_divider.sv
// testbench top for the srt divider, a table of divisions followed by random ones
`timescale 1ns/100ps
`default_nettype none

module tb_srt_divider
    import srt_div_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RESET_TIMEOUT  = 20;
    localparam int RANDOM_TESTS   = 40;
    localparam int NUM_STIM       = 20;

    typedef struct packed {
        word_t divisor;
        word_t dividend;
        logic  signed_mode;
        logic  back_to_back;
    } stim_t;

    logic        clk;
    logic        reset;
    logic        div;
    logic        div_signed;
    word_t       x;
    word_t       y;
    word_t       q;
    word_t       rem;
    logic        complete;
    logic        div0_err;
    int          tests;
    int          errors;
    logic [31:0] lfsr;
    bit          timed_out;
    stim_t       stim_table [NUM_STIM];

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    srt_divider DUT (
        .clk        (clk),
        .reset      (reset),
        .div        (div),
        .div_signed (div_signed),
        .x          (x),
        .y          (y),
        .q          (q),
        .rem        (rem),
        .complete   (complete),
        .div0_err   (div0_err)
    );

    result_checker u_result_checker (
        .clk        (clk),
        .reset      (reset),
        .div        (div),
        .div_signed (div_signed),
        .x          (x),
        .y          (y),
        .q          (q),
        .rem        (rem),
        .complete   (complete),
        .div0_err   (div0_err),
        .tests      (tests),
        .errors     (errors)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic random_bits(input int count, output word_t value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[WORD_W-2:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic random_entry(output stim_t s);
        word_t shift_amt;
        word_t flags;
        random_bits(32, s.dividend);
        random_bits(32, s.divisor);
        // spread the divisor width so quotients get long
        random_bits(5, shift_amt);
        s.divisor = s.divisor >> shift_amt;
        random_bits(2, flags);
        s.signed_mode  = flags[0];
        s.back_to_back = flags[1];
    endtask

    task automatic wait_complete(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
            @(negedge clk);
            seen = complete;
        end
        if (!seen) begin
            $display("no complete within %0d cycles, stuck at %0d ns", TIMEOUT_CYCLES, $time);
        end
    endtask

    task automatic run_division(input stim_t s, output bit seen);
        @(posedge clk);
        x          <= s.dividend;
        y          <= s.divisor;
        div_signed <= s.signed_mode;
        div        <= 1'b1;
        wait_complete(seen);
        // with div held high the same operands run again straight away
        if (seen && s.back_to_back) begin
            wait_complete(seen);
        end
        @(posedge clk);
        div <= 1'b0;
    endtask

    initial begin : stimulus
        stim_t s;
        bit    seen;
        div        = 1'b0;
        div_signed = 1'b0;
        x          = '0;
        y          = '0;
        lfsr       = 32'h7c2f_121e;
        timed_out  = 1'b0;
        // divisor, dividend, signed, back to back
        stim_table = '{
            '{word_t'(7), word_t'(100), 1'b0, 1'b0},
            '{word_t'(9), word_t'(5), 1'b0, 1'b0},
            '{word_t'(13), word_t'(0), 1'b0, 1'b0},
            '{word_t'(1), 32'hffff_ffff, 1'b0, 1'b0},
            '{32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0},
            '{word_t'(16), 32'h1234_5678, 1'b0, 1'b0},
            '{word_t'(3), 32'h8000_0000, 1'b0, 1'b0},
            '{word_t'(2), word_t'(-7), 1'b1, 1'b0},
            '{word_t'(-2), word_t'(7), 1'b1, 1'b0},
            '{word_t'(-2), word_t'(-7), 1'b1, 1'b0},
            '{word_t'(2), word_t'(7), 1'b1, 1'b0},
            '{word_t'(-1), 32'h8000_0000, 1'b1, 1'b0},
            '{word_t'(1), 32'h8000_0000, 1'b1, 1'b0},
            '{word_t'(0), word_t'(55), 1'b0, 1'b0},
            '{word_t'(0), word_t'(-9), 1'b1, 1'b0},
            '{word_t'(33), word_t'(1000), 1'b0, 1'b0},
            '{word_t'(89), word_t'(1234567), 1'b0, 1'b1},
            '{word_t'(37), word_t'(-100000), 1'b1, 1'b1},
            '{word_t'(0), word_t'(5), 1'b0, 1'b1},
            '{word_t'(7), 32'hffff_ffff, 1'b1, 1'b0}
        };
        seen = 1'b0;
        for (int n = 0; n < RESET_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = !reset;
        end
        if (!seen) begin
            $display("reset still high after %0d cycles", RESET_TIMEOUT);
            timed_out = 1'b1;
        end
        for (int i = 0; i < NUM_STIM && !timed_out; i++) begin
            run_division(stim_table[i], seen);
            timed_out = !seen;
        end
        for (int i = 0; i < RANDOM_TESTS && !timed_out; i++) begin
            random_entry(s);
            run_division(s, seen);
            timed_out = !seen;
        end
        $display("%0d tests, %0d errors, timeout %0b", tests, errors, timed_out);
        if (errors == 0 && !timed_out && tests > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: srt_divider.f
source/srt_div_pkg.sv
source/leading_zero_counter.sv
source/operand_prep.sv
source/srt_iteration.sv
source/result_fixup.sv
source/srt_divider.sv
verif/clock_gen.sv
verif/result_checker.sv
verif/tb_srt_divider.sv
